/* hdl/sdmac_defines.svh */
// Width and depth settings for the SCSI DMA data path
// Include in every file that sizes a host word, a SCSI halfword or the FIFO
`ifndef SDMAC_DEFINES_SVH
`define SDMAC_DEFINES_SVH

// Host bus word
`define DP_WORD_W 32

// SCSI data port, one half of a host word
`define DP_HALF_W 16

// Words held by the DMA FIFO
`define DP_FIFO_DEPTH 8

`endif

/* hdl/sdmac_pkg.sv */
// Shared types for the SCSI DMA data path
// Blocks that decode the transfer direction or the host lane enables import this
package sdmac_pkg;

    // Active transfer, one code per route through the data path
    // Code 3'b111 is never driven by the bus side
    typedef enum logic [2:0] {
        dirIdle      = 3'd0,
        dirCpu2Scsi  = 3'd1,
        dirScsi2Cpu  = 3'd2,
        dirScsi2Fifo = 3'd3,
        dirFifo2Scsi = 3'd4,
        dirFifo2Cpu  = 3'd5,
        dirCpu2Fifo  = 3'd6
    } xferDir_t;

    // Which 16-bit halves of the host word are enabled
    typedef struct packed {
        logic high;
        logic low;
    } laneEn_t;

endpackage

/* hdl/dp_bus_if.sv */
// Internal word buses of the data path
// Carries the decoded direction, the host lane enables and the words passed
// between the host latch, the SCSI port and the FIFO
`include "sdmac_defines.svh"

interface dp_bus_if import sdmac_pkg::*; ();

    xferDir_t              dir;
    laneEn_t               hostLanes;
    logic [`DP_WORD_W-1:0] cpuWord;
    logic [`DP_WORD_W-1:0] scsiWord;
    logic [`DP_WORD_W-1:0] fifoOut;
    logic [`DP_WORD_W-1:0] fifoIn;

    // Control owns the direction, the lane enables and the FIFO input mux
    modport ctrl (output dir, hostLanes, fifoIn, input cpuWord, scsiWord);

    // Host input latch only needs to know which halves to take
    modport hostIn (input hostLanes, output cpuWord);

    // Host output picks between the FIFO head and the SCSI word
    modport hostOut (input dir, fifoOut, scsiWord);

    // SCSI port packs into scsiWord and unpacks from the FIFO or the host latch
    modport scsi (input dir, cpuWord, fifoOut, output scsiWord);

    // FIFO writes fifoIn and shows its head word on fifoOut
    modport fifo (input fifoIn, output fifoOut);

endinterface

/* hdl/dp_control.sv */
// Direction decode and enable generation for the data path
// Turns the direction code and the host strobes into host lane enables, the
// FIFO input select and the host data output enable
module dp_control import sdmac_pkg::*; (
    input  logic       CLK,
    input  logic       reset,
    input  logic [2:0] dirSel,
    input  logic       hostWrite,
    input  logic       hostRead,
    dp_bus_if.ctrl     bus,
    output logic       dataOe
);

    xferDir_t dir;
    laneEn_t  lanes;
    logic     cpu2Scsi;
    logic     scsi2Fifo;

    // The bus side hands over a raw code, give it its enum meaning here
    assign dir = xferDir_t'(dirSel);
    assign bus.dir = dir;

    assign cpu2Scsi = (dir == dirCpu2Scsi);
    assign scsi2Fifo = (dir == dirScsi2Fifo);

    // Both halves open on a host write
    // They also stay open for the whole CPU-to-SCSI transfer, as in the
    // DIEL-or-CPU2S input enable term
    assign lanes.high = hostWrite | cpu2Scsi;
    assign lanes.low = hostWrite | cpu2Scsi;
    assign bus.hostLanes = lanes;

    // FIFO is filled from the packed SCSI word on SCSI-to-FIFO transfers
    // Every other fill comes from the host latch
    assign bus.fifoIn = scsi2Fifo ? bus.scsiWord : bus.cpuWord;

    // Output enable follows a read one clock later and drops on the first
    // clock without a read
    always_ff @(posedge CLK) begin
        if (reset) begin
            dataOe <= 1'b0;
        end else begin
            dataOe <= hostRead;
        end
    end

    // Code 3'b111 has no route, so the bus side must never select it
    assert property (@(posedge CLK) disable iff (reset)
        !$isunknown(dirSel) && (dirSel != 3'b111))
        else $error("dirSel carries an unused direction code %b", dirSel);

endmodule

/* hdl/dp_host_in.sv */
// Host input latch
// Holds the host write word per 16-bit half, as enabled by the control block,
// and bypasses the latch entirely while the bridge level is high
`include "sdmac_defines.svh"

module dp_host_in (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic [`DP_WORD_W-1:0] dataIn,
    input  logic                  hostWrite,
    input  logic                  bridge,
    dp_bus_if.hostIn              bus
);

    logic [`DP_HALF_W-1:0] latchHigh;
    logic [`DP_HALF_W-1:0] latchLow;
    logic                  takeHigh;
    logic                  takeLow;

    // Each half is taken on a host write cycle while its lane is enabled
    assign takeHigh = hostWrite & bus.hostLanes.high;
    assign takeLow = hostWrite & bus.hostLanes.low;

    // Latched word shows up one clock after the write strobe
    always_ff @(posedge CLK) begin
        if (reset) begin
            latchHigh <= '0;
            latchLow <= '0;
        end else begin
            if (takeHigh) begin
                latchHigh <= dataIn[`DP_WORD_W-1:`DP_HALF_W];
            end
            if (takeLow) begin
                latchLow <= dataIn[`DP_HALF_W-1:0];
            end
        end
    end

    // In bridge mode the host word goes straight through in the same cycle
    assign bus.cpuWord = bridge ? dataIn : {latchHigh, latchLow};

endmodule

/* hdl/dp_host_out.sv */
// Host output register
// Picks the FIFO head, the packed SCSI word or the register read word for
// each half and registers the result on a host read
`include "sdmac_defines.svh"

module dp_host_out import sdmac_pkg::*; (
    input  logic                   CLK,
    input  logic                   reset,
    input  logic                   hostRead,
    input  logic [`DP_WORD_W-1:0]  regOut,
    dp_bus_if.hostOut              bus,
    output logic [`DP_WORD_W-1:0]  dataOut
);

    laneEn_t               fifoLanes;
    logic [`DP_WORD_W-1:0] modTx;
    logic [`DP_WORD_W-1:0] txWord;

    // FIFO drives both halves when the host drains the FIFO
    assign fifoLanes.high = (bus.dir == dirFifo2Cpu);
    assign fifoLanes.low = (bus.dir == dirFifo2Cpu);

    // Direct SCSI read returns the packed word, anything else the register
    assign modTx = (bus.dir == dirScsi2Cpu) ? bus.scsiWord : regOut;

    // Per-half select between the FIFO head and the word above
    assign txWord[`DP_WORD_W-1:`DP_HALF_W] = fifoLanes.high ?
        bus.fifoOut[`DP_WORD_W-1:`DP_HALF_W] : modTx[`DP_WORD_W-1:`DP_HALF_W];
    assign txWord[`DP_HALF_W-1:0] = fifoLanes.low ?
        bus.fifoOut[`DP_HALF_W-1:0] : modTx[`DP_HALF_W-1:0];

    // Data is valid on the bus the cycle after the read strobe
    always_ff @(posedge CLK) begin
        if (reset) begin
            dataOut <= '0;
        end else if (hostRead) begin
            dataOut <= txWord;
        end
    end

endmodule

/* hdl/dp_scsi_port.sv */
// SCSI side word packer and unpacker
// Packs two halfwords from the SCSI port into one host word, high half first,
// and splits FIFO or host words back into halfwords for the SCSI port
`include "sdmac_defines.svh"

module dp_scsi_port import sdmac_pkg::*; (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic [`DP_HALF_W-1:0] scsiIn,
    input  logic                  scsiStrobe,
    output logic [`DP_HALF_W-1:0] scsiOut,
    output logic                  pushReq,
    output logic                  popReq,
    dp_bus_if.scsi                bus
);

    logic                  packMode;
    logic                  unpackMode;
    logic                  halfSel;
    logic [`DP_HALF_W-1:0] packHigh;
    logic [`DP_WORD_W-1:0] packWord;
    logic [`DP_HALF_W-1:0] lowHold;
    logic [`DP_WORD_W-1:0] srcWord;

    assign packMode = (bus.dir == dirScsi2Fifo) || (bus.dir == dirScsi2Cpu);
    assign unpackMode = (bus.dir == dirFifo2Scsi) || (bus.dir == dirCpu2Scsi);

    // Word to unpack, the FIFO head in DMA mode or the host latch otherwise
    assign srcWord = (bus.dir == dirFifo2Scsi) ? bus.fifoOut : bus.cpuWord;

    // First strobe of a pair consumes the FIFO head word
    assign popReq = scsiStrobe && !halfSel && (bus.dir == dirFifo2Scsi);

    // halfSel low means the next strobe carries the high half
    always_ff @(posedge CLK) begin
        if (reset) begin
            halfSel <= 1'b0;
            scsiOut <= '0;
            pushReq <= 1'b0;
        end else begin
            pushReq <= 1'b0;
            if (!(packMode || unpackMode)) begin
                halfSel <= 1'b0;
            end else if (scsiStrobe) begin
                halfSel <= !halfSel;
                if (unpackMode) begin
                    scsiOut <= halfSel ? lowHold : srcWord[`DP_WORD_W-1:`DP_HALF_W];
                end else if (halfSel && (bus.dir == dirScsi2Fifo)) begin
                    // Push lands in the same cycle the packed word is valid
                    pushReq <= 1'b1;
                end
            end
        end
    end

    // High half waits in packHigh so scsiWord only changes on a full pair
    always_ff @(posedge CLK) begin
        if (scsiStrobe && packMode) begin
            if (halfSel) begin
                packWord <= {packHigh, scsiIn};
            end else begin
                packHigh <= scsiIn;
            end
        end
        if (scsiStrobe && unpackMode && !halfSel) begin
            lowHold <= srcWord[`DP_HALF_W-1:0];
        end
    end

    assign bus.scsiWord = packWord;

    // The bus side must not strobe the SCSI port with no transfer selected
    assert property (@(posedge CLK) disable iff (reset)
        !(scsiStrobe && (bus.dir == dirIdle)))
        else $error("scsiStrobe seen while the direction is idle");

endmodule

/* hdl/dp_fifo.sv */
// DMA word FIFO between the SCSI side and the host side
// Circular buffer with first-word-fall-through output, pushes on a full FIFO
// are dropped and pops on an empty FIFO leave the stale head in place
`include "sdmac_defines.svh"

module dp_fifo (
    input  logic   CLK,
    input  logic   reset,
    input  logic   push,
    input  logic   pop,
    dp_bus_if.fifo bus,
    output logic   fifoEmpty,
    output logic   fifoFull
);

    localparam int Depth = `DP_FIFO_DEPTH;
    localparam int PtrW = $clog2(Depth);
    localparam int CntW = $clog2(Depth + 1);

    logic [`DP_WORD_W-1:0] mem [Depth];
    logic [PtrW-1:0]       wrPtr;
    logic [PtrW-1:0]       rdPtr;
    logic [CntW-1:0]       count;
    logic                  wrEn;
    logic                  rdEn;

    // Pointers wrap explicitly so any depth works, not only powers of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Flags come from the count, so a push shows up one clock later
    assign fifoEmpty = (count == '0);
    assign fifoFull = (count == CntW'(Depth));
    assign wrEn = push && !fifoFull;
    assign rdEn = pop && !fifoEmpty;

    // Head word is always visible
    assign bus.fifoOut = mem[rdPtr];

    always_ff @(posedge CLK) begin
        if (wrEn) begin
            mem[wrPtr] <= bus.fifoIn;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (rdEn) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // No back-pressure exists, so the SCSI side must never overrun the FIFO
    assert property (@(posedge CLK) disable iff (reset) push |-> !fifoFull)
        else $error("push into a full FIFO, word dropped");

endmodule

/* hdl/datapath.sv */
// Top level of the SCSI DMA data path
// Joins the 32-bit host bus and the 16-bit SCSI port through the host latch,
// the output register, the SCSI packer and the DMA FIFO
`include "sdmac_defines.svh"

module datapath (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic [`DP_WORD_W-1:0] dataIn,
    output logic [`DP_WORD_W-1:0] dataOut,
    output logic                  dataOe,
    input  logic [`DP_WORD_W-1:0] regOut,
    input  logic                  hostWrite,
    input  logic                  hostRead,
    input  logic                  bridge,
    input  logic [2:0]            dirSel,
    input  logic [`DP_HALF_W-1:0] scsiIn,
    input  logic                  scsiStrobe,
    output logic [`DP_HALF_W-1:0] scsiOut,
    output logic                  fifoEmpty,
    output logic                  fifoFull
);

    logic pushReq;
    logic popReq;

    dp_bus_if dpBus ();

    dp_control u_dp_control (
        .CLK(CLK), .reset(reset), .dirSel(dirSel), .hostWrite(hostWrite),
        .hostRead(hostRead), .bus(dpBus.ctrl), .dataOe(dataOe)
    );

    dp_host_in u_dp_host_in (
        .CLK(CLK), .reset(reset), .dataIn(dataIn), .hostWrite(hostWrite),
        .bridge(bridge), .bus(dpBus.hostIn)
    );

    dp_host_out u_dp_host_out (
        .CLK(CLK), .reset(reset), .hostRead(hostRead), .regOut(regOut),
        .bus(dpBus.hostOut), .dataOut(dataOut)
    );

    // SCSI side requests drive the FIFO directly
    dp_scsi_port u_dp_scsi_port (
        .CLK(CLK), .reset(reset), .scsiIn(scsiIn), .scsiStrobe(scsiStrobe),
        .scsiOut(scsiOut), .pushReq(pushReq), .popReq(popReq), .bus(dpBus.scsi)
    );

    dp_fifo u_dp_fifo (
        .CLK(CLK), .reset(reset), .push(pushReq), .pop(popReq),
        .bus(dpBus.fifo), .fifoEmpty(fifoEmpty), .fifoFull(fifoFull)
    );

endmodule

/* verif/datapath_tb.sv */
// Testbench for the SCSI DMA data path
// Drives host and SCSI strobes on the falling clock edge, predicts dataOut,
// scsiOut and the FIFO flags with a reference model and compares them
`include "sdmac_defines.svh"

module datapath_tb import sdmac_pkg::*; ();

    logic                  CLK;
    logic                  reset;
    logic [`DP_WORD_W-1:0] dataIn;
    logic [`DP_WORD_W-1:0] dataOut;
    logic                  dataOe;
    logic [`DP_WORD_W-1:0] regOut;
    logic                  hostWrite;
    logic                  hostRead;
    logic                  bridge;
    logic [2:0]            dirSel;
    logic [`DP_HALF_W-1:0] scsiIn;
    logic                  scsiStrobe;
    logic [`DP_HALF_W-1:0] scsiOut;
    logic                  fifoEmpty;
    logic                  fifoFull;

    integer                seed;
    int                    errCount;
    int                    errBase;
    int                    checkCount;
    logic [`DP_WORD_W-1:0] fifoModel[$];

    // Pending comparisons, kind 0 dataOut, 1 scsiOut, 2 dataOe, 3 fifoEmpty, 4 fifoFull
    int                    kindQ[$];
    logic [`DP_WORD_W-1:0] expQ[$];
    string                 nameQ[$];

    datapath i_datapath (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Expected word on the selected route
    // Unpack directions return the whole source word, the caller picks the half
    function automatic logic [`DP_WORD_W-1:0] expectWord(input xferDir_t dir,
        input logic [`DP_WORD_W-1:0] fifoHead, input logic [`DP_WORD_W-1:0] scsiHalves,
        input logic [`DP_WORD_W-1:0] regWord, input logic [`DP_WORD_W-1:0] cpuWord);
        case (dir)
            dirFifo2Cpu, dirFifo2Scsi: return fifoHead;
            dirScsi2Cpu: return scsiHalves;
            dirCpu2Scsi: return cpuWord;
            default: return regWord;
        endcase
    endfunction

    task automatic queueCheck(input int kind, input logic [`DP_WORD_W-1:0] value,
        input string what);
        kindQ.push_back(kind);
        expQ.push_back(value);
        nameQ.push_back(what);
    endtask

    // Outputs are all registered, so a look just after the falling edge is stable
    always @(negedge CLK) begin : compareOutputs
        logic [`DP_WORD_W-1:0] got;
        #1;
        while (kindQ.size() != 0) begin
            case (kindQ[0])
                0: got = dataOut;
                1: got = {16'h0, scsiOut};
                2: got = {31'h0, dataOe};
                3: got = {31'h0, fifoEmpty};
                default: got = {31'h0, fifoFull};
            endcase
            checkCount++;
            assert (got === expQ[0]) else begin
                errCount++;
                $display("ERROR at %0t: %s is %h, expected %h", $time, nameQ[0], got, expQ[0]);
            end
            kindQ.delete(0);
            expQ.delete(0);
            nameQ.delete(0);
        end
    end

    // One strobe cycle followed by one quiet cycle, which also covers a push
    task automatic scsiPulse(input logic [`DP_HALF_W-1:0] half);
        scsiIn = half;
        scsiStrobe = 1'b1;
        @(negedge CLK);
        scsiStrobe = 1'b0;
        @(negedge CLK);
    endtask

    task automatic writePulse(input logic [`DP_WORD_W-1:0] word);
        dataIn = word;
        hostWrite = 1'b1;
        @(negedge CLK);
        hostWrite = 1'b0;
    endtask

    task automatic readPulse();
        hostRead = 1'b1;
        @(negedge CLK);
        hostRead = 1'b0;
    endtask

    // Lets the compare process catch up, then reports the test
    task automatic endTest(input string name);
        int n;
        n = 0;
        while (kindQ.size() != 0 && n < 100) begin
            @(negedge CLK);
            n++;
        end
        if (kindQ.size() != 0) begin
            $display("Timed out after 100 cycles waiting for the output compare");
            $display("TEST FAILED");
            $finish;
        end
        $display("%s: %0d errors", name, errCount - errBase);
        errBase = errCount;
    endtask

    initial begin : stimulus
        logic [`DP_WORD_W-1:0] w;
        logic [`DP_WORD_W-1:0] e;
        logic [`DP_HALF_W-1:0] hi;
        logic [`DP_HALF_W-1:0] lo;
        seed = 32'ha9ee35c1;
        errCount = 0;
        errBase = 0;
        checkCount = 0;
        reset = 1'b1;
        dataIn = '0;
        regOut = '0;
        hostWrite = 1'b0;
        hostRead = 1'b0;
        bridge = 1'b0;
        dirSel = dirIdle;
        scsiIn = '0;
        scsiStrobe = 1'b0;
        repeat (10) @(negedge CLK);
        reset = 1'b0;

        queueCheck(2, 0, "dataOe");
        queueCheck(3, 1, "fifoEmpty");
        queueCheck(4, 0, "fifoFull");
        queueCheck(1, 0, "scsiOut");
        endTest("Reset state");

        // Host word goes out on the SCSI port high half first
        dirSel = dirCpu2Scsi;
        w = $random(seed);
        writePulse(w);
        // The latch must keep the written word once dataIn moves on
        dataIn = $random(seed);
        e = expectWord(dirCpu2Scsi, '0, '0, regOut, w);
        scsiPulse('0);
        queueCheck(1, e[31:16], "scsiOut high half");
        scsiPulse('0);
        queueCheck(1, e[15:0], "scsiOut low half");
        endTest("CPU to SCSI");

        dirSel = dirScsi2Fifo;
        for (int i = 0; i < 4; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            scsiPulse(hi);
            queueCheck(3, fifoModel.size() == 0, "fifoEmpty before push");
            scsiPulse(lo);
            fifoModel.push_back({hi, lo});
            queueCheck(3, 0, "fifoEmpty after push");
        end
        endTest("SCSI to FIFO packing");

        // Host sees the head word, then the SCSI side pops it as two halves
        while (fifoModel.size() != 0) begin
            dirSel = dirFifo2Cpu;
            readPulse();
            queueCheck(0, expectWord(dirFifo2Cpu, fifoModel[0], '0, regOut, '0),
                "dataOut FIFO head");
            dirSel = dirFifo2Scsi;
            e = expectWord(dirFifo2Scsi, fifoModel[0], '0, regOut, '0);
            scsiPulse('0);
            queueCheck(1, e[31:16], "scsiOut FIFO high half");
            // Only the pop of the last word empties the FIFO
            queueCheck(3, fifoModel.size() == 1, "fifoEmpty after pop");
            scsiPulse('0);
            queueCheck(1, e[15:0], "scsiOut FIFO low half");
            fifoModel.delete(0);
        end
        endTest("FIFO drain to CPU and SCSI");

        dirSel = dirIdle;
        regOut = $random(seed);
        readPulse();
        queueCheck(0, expectWord(dirIdle, '0, '0, regOut, '0), "dataOut register word");
        queueCheck(2, 1, "dataOe after read");
        @(negedge CLK);
        queueCheck(2, 0, "dataOe after quiet cycle");
        endTest("Idle register read");

        dirSel = dirScsi2Cpu;
        hi = $random(seed);
        lo = $random(seed);
        scsiPulse(hi);
        scsiPulse(lo);
        readPulse();
        queueCheck(0, expectWord(dirScsi2Cpu, '0, {hi, lo}, regOut, '0), "dataOut SCSI word");

        // Bridge passes dataIn through without a host write
        dirSel = dirCpu2Scsi;
        bridge = 1'b1;
        w = $random(seed);
        dataIn = w;
        e = expectWord(dirCpu2Scsi, '0, '0, regOut, w);
        scsiPulse('0);
        queueCheck(1, e[31:16], "scsiOut bridge high half");
        scsiPulse('0);
        queueCheck(1, e[15:0], "scsiOut bridge low half");
        bridge = 1'b0;
        dirSel = dirIdle;
        endTest("SCSI to CPU and bridge");

        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hdl
hdl/sdmac_pkg.sv
hdl/dp_bus_if.sv
hdl/dp_control.sv
hdl/dp_host_in.sv
hdl/dp_host_out.sv
hdl/dp_scsi_port.sv
hdl/dp_fifo.sv
hdl/datapath.sv
verif/datapath_tb.sv

/* Bender.yml */
package:
  name: sdmac_datapath

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sdmac_pkg.sv
      - hdl/dp_bus_if.sv
      - hdl/dp_control.sv
      - hdl/dp_host_in.sv
      - hdl/dp_host_out.sv
      - hdl/dp_scsi_port.sv
      - hdl/dp_fifo.sv
      - hdl/datapath.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/datapath_tb.sv
